/* project.f */
agcPkg.sv
agcCtrlIf.sv
agcRegs.sv
agcChannelFilter.sv
combAgcLoopFilter.sv
tbAgcLoopFilter.sv

/* Makefile */
# Verilator build and run for the AGC loop filter

VERILATOR ?= verilator
TOP       ?= tbAgcLoopFilter
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "all tests passed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tbAgcLoopFilter.sv */
// AGC loop filter testbench
`timescale 1ns/1ps
`default_nettype none

module tbAgcLoopFilter
    import agcPkg::*;
();

    typedef struct {
        logic [31:0] setReg;
        logic [31:0] gainReg;
        logic [31:0] upper;
        logic [31:0] lower;
        logic [7:0]  enPat;
        logic [11:0] lvl0;
        logic [11:0] lvl1;
        int          cycles;
        bit          rnd;
    } stimRow;

    logic        clk;
    logic        reset;
    logic        clkEn;
    logic        cs;
    logic        wr0;
    logic        wr1;
    logic        wr2;
    logic        wr3;
    logic [5:0]  addr;
    logic [31:0] din;
    logic [31:0] dout;
    logic [11:0] signalLevel0;
    logic [11:0] signalLevel1;
    logic [31:0] loopOutput0;
    logic [31:0] loopOutput1;
    logic        agcBypass;

    // Register images and per-channel model state
    logic [31:0]        regSet;
    logic [31:0]        regGain;
    logic [31:0]        regUpper;
    logic [31:0]        regLower;
    logic signed [11:0] mErr [2];
    logic [31:0]        mLead [2];
    logic [31:0]        mInteg [2];
    logic [31:0]        lfsr;
    stimRow             stimTable[$];
    int                 cycleCount;
    int                 timeoutLimit = 1000000;

    combAgcLoopFilter u_dut (
        .clk          (clk),
        .reset        (reset),
        .clkEn        (clkEn),
        .cs           (cs),
        .wr0          (wr0),
        .wr1          (wr1),
        .wr2          (wr2),
        .wr3          (wr3),
        .addr         (addr),
        .din          (din),
        .dout         (dout),
        .signalLevel0 (signalLevel0),
        .signalLevel1 (signalLevel1),
        .loopOutput0  (loopOutput0),
        .loopOutput1  (loopOutput1),
        .agcBypass    (agcBypass)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            $display("Timeout: the run went past %0d cycles", timeoutLimit);
            $display("tests failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per level bit
    function automatic logic [11:0] randomLevel();
        logic [11:0] v;
        v = '0;
        for (int i = 0; i < 12; i++) begin
            v = {v[10:0], lfsr[0]};
            lfsr = nextLfsr(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] d,
                                               input logic [3:0] lanes);
        logic [31:0] v;
        v = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) v[lane*8 +: 8] = d[lane*8 +: 8];
        end
        return v;
    endfunction

    // Error is (setpoint * 16 - level), optionally negated, then halved
    function automatic logic signed [11:0] errorOf(input logic [11:0] level);
        int e;
        e = int'(regSet[7:0]) * 16 - int'(level);
        if (regSet[8]) e = -e;
        e = e >>> 1;
        if (regSet[9]) e = 0;
        return e[11:0];
    endfunction

    function automatic logic [31:0] leadOf(input logic signed [11:0] err);
        int     g;
        longint v;
        g = (err < 0) ? int'(regGain[12:8]) : int'(regGain[4:0]);
        v = longint'(err);
        if (g >= 11) v = v * (longint'(1) << (g - 11));
        else v = v >>> (11 - g);
        return v[31:0];
    endfunction

    function automatic logic [31:0] integOf(input logic [31:0] cur, input logic [31:0] lead);
        longint s;
        s = longint'(cur) + longint'($signed(lead));
        if (s < 0) return regLower;
        else if (s > 64'sh0000_0000_FFFF_FFFF) return regUpper;
        else if (s >= longint'(regUpper)) return regUpper;
        else if (s <= longint'(regLower)) return regLower;
        else return s[31:0];
    endfunction

    function automatic logic [31:0] expectedRead(input logic [5:0] a);
        case (a)
            6'd0: return regSet;
            6'd1: return regGain;
            6'd2: return regUpper;
            6'd3: return regLower;
            6'd4: return {16'h0000, mInteg[0][31:16]};
            6'd5: return {16'h0000, mInteg[1][31:16]};
            default: return 32'h0;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic checkOutputs();
        checkValue("loopOutput0", loopOutput0, mInteg[0]);
        checkValue("loopOutput1", loopOutput1, mInteg[1]);
        checkValue("agcBypass", {31'b0, agcBypass}, {31'b0, regSet[10]})
;
    endtask

    // Model step and register image update at each clock edge, then the output check
    task automatic tick();
        logic signed [11:0] nextErr;
        @(posedge clk);
        for (int ch = 0; ch < 2; ch++) begin
            nextErr = errorOf(ch == 0 ? signalLevel0 : signalLevel1);
            if (regSet[10]) mInteg[ch] = UnityGain;
            else if (clkEn) mInteg[ch] = integOf(mInteg[ch], mLead[ch]);
            if (clkEn) mLead[ch] = leadOf(mErr[ch]);
            mErr[ch] = nextErr;
        end
        if (cs) begin
            case (addr)
                6'd0: regSet = mergeLanes(regSet, din, {wr3, wr2, wr1, wr0}) & 32'h0000_07FF;
                6'd1: regGain = mergeLanes(regGain, din, {wr3, wr2, wr1, wr0}) & 32'h0000_1F1F;
                6'd2: regUpper = mergeLanes(regUpper, din, {wr3, wr2, wr1, wr0});
                6'd3: regLower = mergeLanes(regLower, din, {wr3, wr2, wr1, wr0});
                default: begin
                end
            endcase
        end
        #1;
        checkOutputs();
    endtask

    task automatic writeReg(input logic [5:0] a, input logic [31:0] d, input logic [3:0] lanes);
        cs = 1'b1;
        addr = a;
        din = d;
        {wr3, wr2, wr1, wr0} = lanes;
        tick();
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    // Combinational read checked before the edge, one clock per access
    task automatic readCheck(input logic [5:0] a, input string name);
        cs = 1'b1;
        addr = a;
        #2;
        checkValue(name, dout, expectedRead(a));
        tick();
        cs = 1'b0;
    endtask

    task automatic readAll();
        readCheck(RegSetpoint, "RegSetpoint");
        readCheck(RegGain, "RegGain");
        readCheck(RegUpper, "RegUpper");
        readCheck(RegLower, "RegLower");
        readCheck(RegInteg0, "RegInteg0");
        readCheck(RegInteg1, "RegInteg1");
        readCheck(6'd9, "unmapped");
    endtask

    task automatic addRow(input logic [31:0] s, input logic [31:0] g, input logic [31:0] up,
                          input logic [31:0] lo, input logic [7:0] en, input logic [11:0] l0,
                          input logic [11:0] l1, input int n, input bit rnd);
        stimRow row;
        row = '{s, g, up, lo, en, l0, l1, n, rnd};
        stimTable.push_back(row);
    endtask

    initial begin
        int total;
        clk = 1'b0;
        reset = 1'b1;
        clkEn = 1'b0;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        addr = '0;
        din = '0;
        signalLevel0 = '0;
        signalLevel1 = '0;
        cycleCount = 0;
        lfsr = 32'hd051_2983;
        regSet = '0;
        regGain = '0;
        regUpper = 32'hFFFF_FFFF;
        regLower = '0;
        for (int ch = 0; ch < 2; ch++) begin
            mErr[ch] = '0;
            mLead[ch] = '0;
            mInteg[ch] = UnityGain;
        end

        // Bypass, zero error, balanced, gains, invert, clkEn, limits, overflow, random
        addRow(32'h440, 32'h0B0B, 32'hFFFF_FFFF, 32'h0, 8'hFF, 12'h100, 12'h900, 20, 0);
        addRow(32'h240, 32'h0F0F, 32'hFFFF_FFFF, 32'h0, 8'hFF, 12'h123, 12'hABC, 16, 0);
        addRow(32'h040, 32'h0F0F, 32'hFFFF_FFFF, 32'h0, 8'hFF, 12'h400, 12'h400, 16, 0);
        addRow(32'h080, 32'h090C, 32'hFFFF_FFFF, 32'h0, 8'hFF, 12'h700, 12'h900, 30, 0);
        addRow(32'h180, 32'h090C, 32'hFFFF_FFFF, 32'h0, 8'hFF, 12'h700, 12'h900, 30, 0);
        addRow(32'h080, 32'h090C, 32'hFFFF_FFFF, 32'h0, 8'h00, 12'h100, 12'hF00, 12, 0);
        addRow(32'h080, 32'h0C0A, 32'hFFFF_FFFF, 32'h0, 8'hA5, 12'h600, 12'hA00, 24, 0);
        addRow(32'h080, 32'h1010, 32'h0001_0000, 32'h400, 8'hFF, 12'h000, 12'hFFF, 40, 0);
        addRow(32'h080, 32'h1F1F, 32'hFFFF_FFFF, 32'h0, 8'hFF, 12'h000, 12'hFFF, 20, 0);
        addRow(32'h080, 32'h0A0C, 32'h0800_0000, 32'h100, 8'hF7, 12'h0, 12'h0, 200, 1);
        addRow(32'h160, 32'h0D08, 32'hFFFF_FFFF, 32'h0, 8'hFF, 12'h0, 12'h0, 150, 1);
        total = 0;
        foreach (stimTable[r]) total += stimTable[r].cycles;
        timeoutLimit = 2 * total + 200;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        clkEn = 1'b1;
        checkOutputs();
        readAll();

        // Byte lanes one at a time
        writeReg(RegLower, 32'h1122_3344, 4'b0001);
        writeReg(RegLower, 32'h5566_7788, 4'b0100);
        writeReg(RegUpper, 32'hAABB_CCDD, 4'b1010);
        writeReg(RegGain, 32'h0000_1F05, 4'b0010);
        writeReg(RegSetpoint, 32'h0000_0312, 4'b0001);
        readAll();

        foreach (stimTable[r]) begin
            writeReg(RegSetpoint, stimTable[r].setReg, 4'hF);
            writeReg(RegGain, stimTable[r].gainReg, 4'hF);
            writeReg(RegUpper, stimTable[r].upper, 4'hF);
            writeReg(RegLower, stimTable[r].lower, 4'hF);
            for (int i = 0; i < stimTable[r].cycles; i++) begin
                clkEn = stimTable[r].enPat[i % 8];
                if (stimTable[r].rnd) begin
                    signalLevel0 = randomLevel();
                    signalLevel1 = randomLevel();
                end else begin
                    signalLevel0 = stimTable[r].lvl0;
                    signalLevel1 = stimTable[r].lvl1;
                end
                tick();
            end
            readAll();
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* combAgcLoopFilter.sv */
// Dual-channel AGC loop filter
`timescale 1ns/1ps
`default_nettype none

module combAgcLoopFilter
    import agcPkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  clkEn,
    input  wire logic                  cs,
    input  wire logic                  wr0,
    input  wire logic                  wr1,
    input  wire logic                  wr2,
    input  wire logic                  wr3,
    input  wire logic [5:0]            addr,
    input  wire logic [IntegWidth-1:0] din,
    output logic      [IntegWidth-1:0] dout,
    input  wire logic [LevelWidth-1:0] signalLevel0,
    input  wire logic [LevelWidth-1:0] signalLevel1,
    output logic      [IntegWidth-1:0] loopOutput0,
    output logic      [IntegWidth-1:0] loopOutput1,
    output logic                       agcBypass
);

    agcCtrlIf ctrlBus ();

    agcRegs loopRegs (
        .clk        (clk),
        .reset      (reset),
        .cs         (cs),
        .wr0        (wr0),
        .wr1        (wr1),
        .wr2        (wr2),
        .wr3        (wr3),
        .addr       (addr),
        .din        (din),
        .dout       (dout),
        .integHigh0 (loopOutput0[IntegWidth-1:IntegWidth/2]),
        .integHigh1 (loopOutput1[IntegWidth-1:IntegWidth/2]),
        .ctrl       (ctrlBus.regs)
    );

    // Both channels share one configuration
    agcChannelFilter channel0 (
        .clk         (clk),
        .reset       (reset),
        .clkEn       (clkEn),
        .signalLevel (signalLevel0),
        .ctrl        (ctrlBus.filter),
        .loopOutput  (loopOutput0)
    );

    agcChannelFilter channel1 (
        .clk         (clk),
        .reset       (reset),
        .clkEn       (clkEn),
        .signalLevel (signalLevel1),
        .ctrl        (ctrlBus.filter),
        .loopOutput  (loopOutput1)
    );

    assign agcBypass = ctrlBus.byPassAgc;

endmodule

`default_nettype wire

/* agcChannelFilter.sv */
// AGC loop filter for one channel
`timescale 1ns/1ps
`default_nettype none

module agcChannelFilter
    import agcPkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  clkEn,
    input  wire logic [LevelWidth-1:0] signalLevel,
    agcCtrlIf.filter                   ctrl,
    output logic      [IntegWidth-1:0] loopOutput
);

    // Gain code where the error passes unshifted
    localparam logic [GainWidth-1:0] UnityShift = 5'd11;

    logic signed [LevelWidth:0]   errorRaw;
    logic signed [LevelWidth:0]   errorAdj;
    logic signed [LevelWidth-1:0] loopError;
    logic [GainWidth-1:0]         loopGain;
    logic signed [IntegWidth-1:0] errorExt;
    logic signed [IntegWidth-1:0] leadNext;
    logic signed [IntegWidth-1:0] leadError;
    logic [IntegWidth:0]          sum;
    logic [IntegWidth-1:0]        integ;

    // Setpoint is in units of 16 level counts
    assign errorRaw = $signed({1'b0, ctrl.setpoint, 4'b0000}) - $signed({1'b0, signalLevel});
    assign errorAdj = ctrl.invertError ? -errorRaw : errorRaw;

    // Stage 1 runs on every edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loopError <= '0;
        end else if (ctrl.zeroError) begin
            loopError <= '0;
        end else begin
            loopError <= errorAdj[LevelWidth:1];
        end
    end

    // Separate gains for each error sign
    assign loopGain = loopError[LevelWidth-1] ? ctrl.negErrorGain : ctrl.posErrorGain;
    assign errorExt = {{(IntegWidth-LevelWidth){loopError[LevelWidth-1]}}, loopError};

    always_comb begin
        if (loopGain >= UnityShift) begin
            leadNext = errorExt <<< (loopGain - UnityShift);
        end else begin
            leadNext = errorExt >>> (UnityShift - loopGain);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            leadError <= '0;
        end else if (clkEn) begin
            leadError <= leadNext;
        end
    end

    // Signed lead added to the unsigned integrator, bit 32 flags carry or borrow
    assign sum = {1'b0, integ} + {leadError[IntegWidth-1], leadError};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            integ <= UnityGain;
        end else if (ctrl.byPassAgc) begin
            integ <= UnityGain;
        end else if (clkEn) begin
            if (sum[IntegWidth] && leadError[IntegWidth-1]) begin
                // Borrow past zero
                integ <= ctrl.lowerLimit;
            end else if (sum[IntegWidth]) begin
                // Carry past full scale
                integ <= ctrl.upperLimit;
            end else if (sum[IntegWidth-1:0] >= ctrl.upperLimit) begin
                integ <= ctrl.upperLimit;
            end else if (sum[IntegWidth-1:0] <= ctrl.lowerLimit) begin
                integ <= ctrl.lowerLimit;
            end else begin
                integ <= sum[IntegWidth-1:0];
            end
        end
    end

    assign loopOutput = integ;

endmodule

`default_nettype wire

/* agcRegs.sv */
// AGC loop register block
`timescale 1ns/1ps
`default_nettype none

module agcRegs
    import agcPkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    cs,
    input  wire logic                    wr0,
    input  wire logic                    wr1,
    input  wire logic                    wr2,
    input  wire logic                    wr3,
    input  wire logic [5:0]              addr,
    input  wire logic [IntegWidth-1:0]   din,
    output logic      [IntegWidth-1:0]   dout,
    input  wire logic [IntegWidth/2-1:0] integHigh0,
    input  wire logic [IntegWidth/2-1:0] integHigh1,
    agcCtrlIf.regs                       ctrl
);

    logic [3:0]               laneWr;
    agcRegAddr                regSel;
    logic [SetpointWidth-1:0] setpoint;
    logic                     invertError;
    logic                     zeroError;
    logic                     byPassAgc;
    logic [GainWidth-1:0]     posErrorGain;
    logic [GainWidth-1:0]     negErrorGain;
    logic [IntegWidth-1:0]    upperLimit;
    logic [IntegWidth-1:0]    lowerLimit;
    logic [IntegWidth-1:0]    readData;

    // Byte lane strobes only count with chip select
    assign laneWr = cs ? {wr3, wr2, wr1, wr0} : 4'b0000;
    assign regSel = agcRegAddr'(addr);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            setpoint     <= '0;
            invertError  <= 1'b0;
            zeroError    <= 1'b0;
            byPassAgc    <= 1'b0;
            posErrorGain <= '0;
            negErrorGain <= '0;
            upperLimit   <= 32'hFFFF_FFFF;
            lowerLimit   <= '0;
        end else begin
            case (regSel)
                RegSetpoint: begin
                    if (laneWr[0]) begin
                        setpoint <= din[7:0];
                    end
                    // Control bits live in lane 1
                    if (laneWr[1]) begin
                        invertError <= din[8];
                        zeroError   <= din[9];
                        byPassAgc   <= din[10];
                    end
                end
                RegGain: begin
                    if (laneWr[0]) begin
                        posErrorGain <= din[4:0];
                    end
                    if (laneWr[1]) begin
                        negErrorGain <= din[12:8];
                    end
                end
                RegUpper: begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (laneWr[lane]) begin
                            upperLimit[lane*8 +: 8] <= din[lane*8 +: 8];
                        end
                    end
                end
                RegLower: begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (laneWr[lane]) begin
                            lowerLimit[lane*8 +: 8] <= din[lane*8 +: 8];
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Readback mux, fields at their register bit positions
    always_comb begin
        readData = '0;
        case (regSel)
            RegSetpoint: begin
                readData[7:0] = setpoint;
                readData[8]   = invertError;
                readData[9]   = zeroError;
                readData[10]  = byPassAgc;
            end
            RegGain: begin
                readData[4:0]  = posErrorGain;
                readData[12:8] = negErrorGain;
            end
            RegUpper:  readData = upperLimit;
            RegLower:  readData = lowerLimit;
            RegInteg0: readData[IntegWidth/2-1:0] = integHigh0;
            RegInteg1: readData[IntegWidth/2-1:0] = integHigh1;
            default:   readData = '0;
        endcase
    end

    assign dout = cs ? readData : '0;

    // Configuration goes straight out to the filters
    assign ctrl.setpoint     = setpoint;
    assign ctrl.invertError  = invertError;
    assign ctrl.zeroError    = zeroError;
    assign ctrl.byPassAgc    = byPassAgc;
    assign ctrl.posErrorGain = posErrorGain;
    assign ctrl.negErrorGain = negErrorGain;
    assign ctrl.upperLimit   = upperLimit;
    assign ctrl.lowerLimit   = lowerLimit;

endmodule

`default_nettype wire

/* agcCtrlIf.sv */
// AGC loop configuration bus
`timescale 1ns/1ps
`default_nettype none

interface agcCtrlIf
    import agcPkg::*;
();
    logic [SetpointWidth-1:0] setpoint;
    logic                     invertError;
    logic                     zeroError;
    logic                     byPassAgc;
    logic [GainWidth-1:0]     posErrorGain;
    logic [GainWidth-1:0]     negErrorGain;
    logic [IntegWidth-1:0]    upperLimit;
    logic [IntegWidth-1:0]    lowerLimit;

    // Register block side
    modport regs (
        output setpoint, invertError, zeroError, byPassAgc,
        output posErrorGain, negErrorGain, upperLimit, lowerLimit
    );

    // Channel filter side
    modport filter (
        input setpoint, invertError, zeroError, byPassAgc,
        input posErrorGain, negErrorGain, upperLimit, lowerLimit
    );

endinterface

`default_nettype wire

/* agcPkg.sv */
// AGC loop filter shared definitions
`default_nettype none

package agcPkg;

    // Datapath widths
    localparam int LevelWidth    = 12;
    localparam int IntegWidth    = 32;
    localparam int SetpointWidth = 8;
    localparam int GainWidth     = 5;

    // Integrator value for a gain of one
    localparam logic [IntegWidth-1:0] UnityGain = 32'h0000_0800;

    // Register map
    typedef enum logic [5:0] {
        RegSetpoint = 6'd0,
        RegGain     = 6'd1,
        RegUpper    = 6'd2,
        RegLower    = 6'd3,
        RegInteg0   = 6'd4,
        RegInteg1   = 6'd5
    } agcRegAddr;

endpackage

`default_nettype wire
